/* Makefile */
# Verilator flow for the transceiver reset controller
# Override any variable on the command line, e.g. make sim TOP=xcvr_reset_tb

VERILATOR ?= verilator
TOP       ?= xcvr_reset_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Status comes from the search, not from the simulator exit code
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* hw/reset_counter.sv */
//**************************************************************************
// Reset hold timer
// Holds its reset output on while requested and for HOLD_CYCLES edges
// after the request drops, with a synchronous override
//**************************************************************************

`timescale 1ns/1ps

module reset_counter #(
  parameter xcvr_reset_pkg::reset_count_t HOLD_CYCLES = 1
) (
  input  logic clock,
  input  logic reset_sync,
  input  logic request,
  input  logic override,
  output logic reset_out
);
  import xcvr_reset_pkg::*;

  reset_count_t count_q;
  reset_count_t count_next;

  // Restart on request, otherwise count up and saturate at the hold
  always_comb begin
    if (request)
      count_next = '0;
    else if (count_q < HOLD_CYCLES)
      count_next = count_q + 1'b1;
    else
      count_next = count_q;
  end

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      count_q   <= '0;
      reset_out <= 1'b1;  // Held on out of reset
    end else begin
      count_q   <= count_next;
      // Registered so the release lands exactly on the hold edge
      reset_out <= (count_next < HOLD_CYCLES) | override;
    end
  end

endmodule

/* hw/rx_reset_seq.sv */
//**************************************************************************
// Receive reset sequencer
// Holds rx_analogreset through calibration, releases rx_digitalreset
// once locked to data and raises rx_ready a fixed time later
//**************************************************************************

`timescale 1ns/1ps
`include "xcvr_reset_defs.svh"

module rx_reset_seq #(
  parameter int CHANNELS = 4
) (
  input  logic                clock,
  input  logic                reset_sync,
  xcvr_status_if.rx_side      status,
  input  logic [CHANNELS-1:0] digitalreset_or,
  output logic                rx_analogreset,
  output logic                rx_digitalreset,
  output logic                rx_ready
);
  import xcvr_reset_pkg::*;

  logic digital_req;
  logic ready_hold;

  // Analog reset during calibration and a short hold after
  reset_counter #(
    .HOLD_CYCLES (reset_count_t'(`XR_T_RX_ANALOGRESET))
  ) analog_timer_i (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (status.rx_cal_busy),
    .override   (1'b0),
    .reset_out  (rx_analogreset)
  );

  // Restart on lost lock unless manual
  assign digital_req = status.rx_cal_busy
                     | rx_analogreset
                     | (~status.rx_locked & ~status.rx_manual);

  reset_counter #(
    .HOLD_CYCLES (reset_count_t'(`XR_T_RX_DIGITALRESET))
  ) digital_timer_i (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (digital_req),
    .override   (|digitalreset_or),
    .reset_out  (rx_digitalreset)
  );

  reset_counter #(
    .HOLD_CYCLES (reset_count_t'(`XR_T_READY))
  ) ready_timer_i (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (rx_digitalreset),
    .override   (1'b0),
    .reset_out  (ready_hold)
  );

  assign rx_ready = ~ready_hold;  // Low while the timer holds

endmodule

/* hw/status_sync.sv */
//**************************************************************************
// PHY status synchronizer
// Combines per-channel status across channels and retimes the result
// into the clock domain through a short flop chain
//**************************************************************************

`timescale 1ns/1ps
`include "xcvr_reset_defs.svh"

module status_sync #(
  parameter int CHANNELS = 4
) (
  input  logic                clock,
  input  logic                reset_sync,
  input  logic [CHANNELS-1:0] tx_cal_busy,
  input  logic [CHANNELS-1:0] tx_manual,
  input  logic [CHANNELS-1:0] rx_cal_busy,
  input  logic [CHANNELS-1:0] rx_manual,
  input  logic [CHANNELS-1:0] rx_is_lockedtodata,
  input  logic                pll_locked,
  xcvr_status_if.sync_side    status
);
  import xcvr_reset_pkg::*;

  // RX starts out busy so its resets hold until calibration is seen clear
  localparam status_bits_t RESET_WORD = '{rx_cal_busy: 1'b1, default: 1'b0};

  status_bits_t raw_word;                     // Combined, not yet retimed
  status_bits_t sync_q [`XR_SYNC_STAGES];     // Retiming chain

  // Shared control across channels
  always_comb begin
    raw_word.tx_cal_busy = |tx_cal_busy;
    raw_word.tx_manual   = |tx_manual;
    raw_word.pll_locked  = pll_locked;
    raw_word.rx_cal_busy = |rx_cal_busy;
    raw_word.rx_locked   = &rx_is_lockedtodata;  // Every channel must lock
    raw_word.rx_manual   = |rx_manual;
  end

  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync) begin
      for (int i = 0; i < `XR_SYNC_STAGES; i++)
        sync_q[i] <= RESET_WORD;
    end else begin
      sync_q[0] <= raw_word;
      for (int i = 1; i < `XR_SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
    end
  end

  assign status.status = sync_q[`XR_SYNC_STAGES-1];  // Last stage out

endmodule

/* hw/tx_reset_seq.sv */
//**************************************************************************
// Transmit reset sequencer
// Releases tx_digitalreset after PLL powerdown and first lock,
// then raises tx_ready a fixed time later
//**************************************************************************

`timescale 1ns/1ps
`include "xcvr_reset_defs.svh"

module tx_reset_seq #(
  parameter int CHANNELS = 4
) (
  input  logic                clock,
  input  logic                reset_sync,
  input  logic                pll_powerdown,
  xcvr_status_if.tx_side      status,
  input  logic [CHANNELS-1:0] digitalreset_or,
  output logic                tx_digitalreset,
  output logic                tx_ready
);
  import xcvr_reset_pkg::*;

  logic lock_seen_q;     // One-shot first lock
  logic digital_req;
  logic ready_hold;      // Ready timer still counting

  // Set once the PLL locks with no calibration running
  always_ff @(posedge clock or posedge reset_sync) begin
    if (reset_sync)
      lock_seen_q <= 1'b0;
    else if (status.pll_locked && !status.tx_cal_busy)
      lock_seen_q <= 1'b1;
  end

  //**************************************************************************
  // Digital reset request
  //**************************************************************************
  assign digital_req = pll_powerdown
                     | status.tx_cal_busy
                     | ~lock_seen_q                               // Before first lock
                     | (~status.pll_locked & ~status.tx_manual);  // Auto restart

  reset_counter #(
    .HOLD_CYCLES (reset_count_t'(`XR_T_TX_DIGITALRESET))
  ) digital_timer_i (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (digital_req),
    .override   (|digitalreset_or),  // Any channel forces it
    .reset_out  (tx_digitalreset)
  );

  // Ready follows the digital reset release
  reset_counter #(
    .HOLD_CYCLES (reset_count_t'(`XR_T_READY))
  ) ready_timer_i (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (tx_digitalreset),
    .override   (1'b0),
    .reset_out  (ready_hold)
  );

  assign tx_ready = ~ready_hold;

endmodule

/* hw/xcvr_reset_control.sv */
//**************************************************************************
// Transceiver reset controller
// Shared reset sequencing for a block of channels on one TX PLL
// PLL powerdown timer, TX and RX sequencers, outputs fanned out per channel
//**************************************************************************

`timescale 1ns/1ps
`include "xcvr_reset_defs.svh"

module xcvr_reset_control #(
  parameter int CHANNELS = 4
) (
  input  logic                clock,
  input  logic                reset_sync,
  input  logic                pll_locked,
  input  logic [CHANNELS-1:0] tx_cal_busy,
  input  logic [CHANNELS-1:0] tx_manual,
  input  logic [CHANNELS-1:0] tx_digitalreset_or,
  input  logic [CHANNELS-1:0] rx_is_lockedtodata,
  input  logic [CHANNELS-1:0] rx_cal_busy,
  input  logic [CHANNELS-1:0] rx_manual,
  input  logic [CHANNELS-1:0] rx_digitalreset_or,
  output logic                pll_powerdown,
  output logic [CHANNELS-1:0] tx_analogreset,
  output logic [CHANNELS-1:0] tx_digitalreset,
  output logic [CHANNELS-1:0] tx_ready,
  output logic [CHANNELS-1:0] rx_analogreset,
  output logic [CHANNELS-1:0] rx_digitalreset,
  output logic [CHANNELS-1:0] rx_ready
);
  import xcvr_reset_pkg::*;

  // Shared control, one copy for all channels
  logic tx_dreset;
  logic tx_rdy;
  logic rx_areset;
  logic rx_dreset;
  logic rx_rdy;

  xcvr_status_if status_if ();

  status_sync #(.CHANNELS(CHANNELS)) status_sync_i (
    .clock              (clock),
    .reset_sync         (reset_sync),
    .tx_cal_busy        (tx_cal_busy),
    .tx_manual          (tx_manual),
    .rx_cal_busy        (rx_cal_busy),
    .rx_manual          (rx_manual),
    .rx_is_lockedtodata (rx_is_lockedtodata),
    .pll_locked         (pll_locked),
    .status             (status_if)
  );

  //**************************************************************************
  // PLL powerdown, a fixed hold after system reset
  //**************************************************************************
  reset_counter #(
    .HOLD_CYCLES (reset_count_t'(`XR_T_PLL_POWERDOWN))
  ) powerdown_timer_i (
    .clock      (clock),
    .reset_sync (reset_sync),
    .request    (1'b0),
    .override   (1'b0),
    .reset_out  (pll_powerdown)
  );

  tx_reset_seq #(.CHANNELS(CHANNELS)) tx_seq_i (
    .clock           (clock),
    .reset_sync      (reset_sync),
    .pll_powerdown   (pll_powerdown),
    .status          (status_if),
    .digitalreset_or (tx_digitalreset_or),
    .tx_digitalreset (tx_dreset),
    .tx_ready        (tx_rdy)
  );

  rx_reset_seq #(.CHANNELS(CHANNELS)) rx_seq_i (
    .clock           (clock),
    .reset_sync      (reset_sync),
    .status          (status_if),
    .digitalreset_or (rx_digitalreset_or),
    .rx_analogreset  (rx_areset),
    .rx_digitalreset (rx_dreset),
    .rx_ready        (rx_rdy)
  );

  // Fanout to every channel
  assign tx_analogreset  = {CHANNELS{pll_powerdown}};  // TX PMA tracks powerdown
  assign tx_digitalreset = {CHANNELS{tx_dreset}};
  assign tx_ready        = {CHANNELS{tx_rdy}};
  assign rx_analogreset  = {CHANNELS{rx_areset}};
  assign rx_digitalreset = {CHANNELS{rx_dreset}};
  assign rx_ready        = {CHANNELS{rx_rdy}};

endmodule

/* hw/xcvr_reset_pkg.sv */
//**************************************************************************
// Transceiver reset sequencer types
// Timer count and the raw PHY status word carried through the synchronizer
//**************************************************************************

`include "xcvr_reset_defs.svh"

package xcvr_reset_pkg;

  typedef logic [`XR_COUNT_WIDTH-1:0] reset_count_t;  // Reset timer count

  // One word of the status retiming chain
  typedef struct packed {
    logic tx_cal_busy;  // OR over channels
    logic tx_manual;    // OR over channels
    logic pll_locked;
    logic rx_cal_busy;  // OR over channels
    logic rx_locked;    // AND of lock-to-data
    logic rx_manual;    // OR over channels
  } status_bits_t;

endpackage

/* hw/xcvr_status_if.sv */
//**************************************************************************
// Synchronized PHY status bundle
// Driven by the input synchronizer and read by the TX and RX sequencers
//**************************************************************************

`timescale 1ns/1ps

interface xcvr_status_if;
  import xcvr_reset_pkg::*;

  status_bits_t status;  // Retimed status word

  // Per-field views for the sequencers
  logic tx_cal_busy;
  logic tx_manual;
  logic pll_locked;
  logic rx_cal_busy;
  logic rx_locked;
  logic rx_manual;

  assign tx_cal_busy = status.tx_cal_busy;
  assign tx_manual   = status.tx_manual;
  assign pll_locked  = status.pll_locked;
  assign rx_cal_busy = status.rx_cal_busy;
  assign rx_locked   = status.rx_locked;
  assign rx_manual   = status.rx_manual;

  modport sync_side (output status);
  modport tx_side (input tx_cal_busy, tx_manual, pll_locked);
  modport rx_side (input rx_cal_busy, rx_locked, rx_manual);

endinterface

/* include/xcvr_reset_defs.svh */
//**************************************************************************
// Transceiver reset sequencer constants
// Counter width, synchronizer depth and every reset period in clock cycles
//**************************************************************************

`ifndef XCVR_RESET_DEFS_SVH
`define XCVR_RESET_DEFS_SVH

// Timer count width for every reset counter
`define XR_COUNT_WIDTH 16

// Retiming flops on the PHY status inputs
`define XR_SYNC_STAGES 2

// Reset hold periods in cycles
`define XR_T_PLL_POWERDOWN   125  // 1 us at 125 MHz
`define XR_T_TX_DIGITALRESET 3
`define XR_T_RX_ANALOGRESET  5
`define XR_T_RX_DIGITALRESET 500

// Digital reset release to ready
`define XR_T_READY 3

`endif

/* testbench/xcvr_reset_checker.sv */
//**************************************************************************
// Transceiver reset controller assertions
// Ready against digital reset, RX reset nesting and fixed release delays
//**************************************************************************

`timescale 1ns/1ps
`include "xcvr_reset_defs.svh"

module xcvr_reset_checker #(
  parameter int CHANNELS = 4
) (
  input logic                clock,
  input logic                reset_sync,
  input logic                pll_powerdown,
  input logic [CHANNELS-1:0] tx_digitalreset,
  input logic [CHANNELS-1:0] tx_ready,
  input logic [CHANNELS-1:0] rx_analogreset,
  input logic [CHANNELS-1:0] rx_digitalreset,
  input logic [CHANNELS-1:0] rx_ready
);

  int fail_count = 0;  // Assertion failures so far

  // Ready drops on the edge after its digital reset rises
  tx_ready_in_reset: assert property (@(posedge clock) disable iff (reset_sync)
    (tx_digitalreset[0] && $past(tx_digitalreset[0])) |-> !tx_ready[0])
    else begin
      fail_count++;
      $error("tx_ready high while tx_digitalreset is held");
    end

  rx_ready_in_reset: assert property (@(posedge clock) disable iff (reset_sync)
    (rx_digitalreset[0] && $past(rx_digitalreset[0])) |-> !rx_ready[0])
    else begin
      fail_count++;
      $error("rx_ready high while rx_digitalreset is held");
    end

  rx_analog_nested: assert property (@(posedge clock) disable iff (reset_sync)
    rx_analogreset[0] |-> rx_digitalreset[0])  // Analog window inside digital
    else begin
      fail_count++;
      $error("rx_analogreset high with rx_digitalreset low");
    end

  tx_ready_delay: assert property (@(posedge clock) disable iff (reset_sync)
    $rose(tx_ready[0]) |-> !$past(tx_digitalreset[0])
                        && !$past(tx_digitalreset[0], `XR_T_READY)
                        && $past(tx_digitalreset[0], `XR_T_READY + 1))
    else begin
      fail_count++;
      $error("tx_ready rise not aligned to tx_digitalreset release");
    end

  // Fixed powerdown hold from reset release
  powerdown_delay: assert property (@(posedge clock)
    $fell(pll_powerdown) |-> !$past(reset_sync, `XR_T_PLL_POWERDOWN)
                          && $past(reset_sync, `XR_T_PLL_POWERDOWN + 1))
    else begin
      fail_count++;
      $error("pll_powerdown release not aligned to reset_sync release");
    end

endmodule

bind xcvr_reset_control xcvr_reset_checker #(.CHANNELS(CHANNELS)) checker_i (
  .clock           (clock),
  .reset_sync      (reset_sync),
  .pll_powerdown   (pll_powerdown),
  .tx_digitalreset (tx_digitalreset),
  .tx_ready        (tx_ready),
  .rx_analogreset  (rx_analogreset),
  .rx_digitalreset (rx_digitalreset),
  .rx_ready        (rx_ready)
);

/* testbench/xcvr_reset_monitor.sv */
//**************************************************************************
// Transceiver reset controller monitor
// Compares settled DUT outputs with the expected row levels on each strobe
//**************************************************************************

`timescale 1ns/1ps

module xcvr_reset_monitor #(
  parameter int CHANNELS = 4
) (
  input  logic                sample,       // Pulsed once per table row
  input  int                  row,
  input  logic [5:0]          expected,     // pd, tx_dr, tx_rdy, rx_ar, rx_dr, rx_rdy
  input  logic                pll_powerdown,
  input  logic [CHANNELS-1:0] tx_analogreset,
  input  logic [CHANNELS-1:0] tx_digitalreset,
  input  logic [CHANNELS-1:0] tx_ready,
  input  logic [CHANNELS-1:0] rx_analogreset,
  input  logic [CHANNELS-1:0] rx_digitalreset,
  input  logic [CHANNELS-1:0] rx_ready,
  output int                  error_count,
  output int                  check_count
);

  int errors = 0;
  int checks = 0;

  // Every channel must carry the same level
  task automatic compare_lanes(input string name, input logic [CHANNELS-1:0] actual,
                               input logic level);
    checks++;
    if (actual !== {CHANNELS{level}}) begin
      errors++;
      $display("FAIL: %0d ns row %0d %s = %b, expected %b on every channel",
               $time, row, name, actual, level);
    end
  endtask

  // Strobe lands mid-cycle, outputs settled
  always @(posedge sample) begin
    compare_lanes("pll_powerdown", {CHANNELS{pll_powerdown}}, expected[5]);
    compare_lanes("tx_analogreset", tx_analogreset, expected[5]);  // Tracks powerdown
    compare_lanes("tx_digitalreset", tx_digitalreset, expected[4]);
    compare_lanes("tx_ready", tx_ready, expected[3]);
    compare_lanes("rx_analogreset", rx_analogreset, expected[2]);
    compare_lanes("rx_digitalreset", rx_digitalreset, expected[1]);
    compare_lanes("rx_ready", rx_ready, expected[0]);
  end

  assign error_count = errors;
  assign check_count = checks;

endmodule

/* testbench/xcvr_reset_tb.sv */
//**************************************************************************
// Transceiver reset controller testbench
// Applies a table of PHY status levels, one row at a time, and has the
// monitor check the settled reset and ready outputs
//**************************************************************************

`timescale 1ns/1ps

module xcvr_reset_tb;

  localparam int CHANNELS       = 4;
  localparam int CLOCK_PERIOD   = 8;   // ns
  localparam int NUM_ROWS       = 19;
  localparam int CHECKS_PER_ROW = 7;
  localparam logic [31:0] SEED  = 32'he99b69ed;

  // stim bits: pll_locked, tx_cal_busy, tx_manual, tx_or,
  //            rx_locked_all, rx_cal_busy, rx_manual, rx_or
  // settled bits: pll_powerdown, tx_digitalreset, tx_ready,
  //               rx_analogreset, rx_digitalreset, rx_ready
  typedef struct packed {
    logic [7:0]  stim;     // Per-channel flags hit one random lane
    logic [15:0] hold;     // Cycles before sampling
    logic [5:0]  settled;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{8'b0000_0100, 16'd10,  6'b110_110},  // Just out of reset
    '{8'b0000_0000, 16'd150, 6'b010_010},  // Powerdown over, PLL not locked
    '{8'b1000_0000, 16'd20,  6'b001_010},  // First lock releases TX
    '{8'b1100_0000, 16'd20,  6'b010_010},  // TX calibration on one lane
    '{8'b1000_0000, 16'd20,  6'b001_010},
    '{8'b0000_0000, 16'd20,  6'b010_010},  // Lock lost, auto restart
    '{8'b1000_0000, 16'd20,  6'b001_010},
    '{8'b0010_0000, 16'd20,  6'b001_010},  // Lock lost under manual
    '{8'b1000_0000, 16'd20,  6'b001_010},
    '{8'b1000_0100, 16'd20,  6'b001_110},  // RX calibration on one lane
    '{8'b1000_1000, 16'd540, 6'b001_001},  // All lanes locked to data
    '{8'b1000_0000, 16'd20,  6'b001_010},  // One lane loses data lock
    '{8'b1000_1000, 16'd540, 6'b001_001},
    '{8'b1000_0010, 16'd20,  6'b001_001},  // Unlocked lane, RX manual
    '{8'b1000_1000, 16'd20,  6'b001_001},
    '{8'b1001_1000, 16'd20,  6'b010_001},  // TX override
    '{8'b1000_1000, 16'd20,  6'b001_001},
    '{8'b1000_1001, 16'd20,  6'b001_010},  // RX override
    '{8'b1000_1000, 16'd20,  6'b001_001}
  };

  logic clock;
  logic reset_sync;
  logic pll_locked;
  logic [CHANNELS-1:0] tx_cal_busy, tx_manual, tx_digitalreset_or;
  logic [CHANNELS-1:0] rx_is_lockedtodata, rx_cal_busy, rx_manual, rx_digitalreset_or;
  logic pll_powerdown;
  logic [CHANNELS-1:0] tx_analogreset, tx_digitalreset, tx_ready;
  logic [CHANNELS-1:0] rx_analogreset, rx_digitalreset, rx_ready;

  logic       sample;       // Monitor strobe
  logic [5:0] expected;
  int         row_index;
  int         error_count;
  int         check_count;

  xcvr_reset_control #(.CHANNELS(CHANNELS)) dut_i (.*);

  xcvr_reset_monitor #(.CHANNELS(CHANNELS)) monitor_i (
    .sample (sample), .row (row_index), .expected (expected),
    .pll_powerdown (pll_powerdown), .tx_analogreset (tx_analogreset),
    .tx_digitalreset (tx_digitalreset), .tx_ready (tx_ready),
    .rx_analogreset (rx_analogreset), .rx_digitalreset (rx_digitalreset),
    .rx_ready (rx_ready), .error_count (error_count), .check_count (check_count)
  );

  // Drive one row, per-channel flags on a single lane
  task automatic apply_row(input row_t row, input int unsigned lane);
    logic [CHANNELS-1:0] one_hot;
    one_hot            = CHANNELS'(1) << lane;
    pll_locked         = row.stim[7];
    tx_cal_busy        = row.stim[6] ? one_hot : '0;
    tx_manual          = row.stim[5] ? one_hot : '0;
    tx_digitalreset_or = row.stim[4] ? one_hot : '0;
    rx_is_lockedtodata = row.stim[3] ? '1 : ~one_hot;  // Else one lane unlocked
    rx_cal_busy        = row.stim[2] ? one_hot : '0;
    rx_manual          = row.stim[1] ? one_hot : '0;
    rx_digitalreset_or = row.stim[0] ? one_hot : '0;
  endtask

  function automatic longint hold_total();
    longint sum;
    sum = 0;
    for (int i = 0; i < NUM_ROWS; i++)
      sum += longint'(rows[i].hold);
    return sum;
  endfunction

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  //**************************************************************************
  // Stimulus
  //**************************************************************************
  initial begin : stimulus
    int unsigned lane;
    void'($urandom(SEED));
    reset_sync         = 1'b1;
    pll_locked         = 1'b0;
    tx_cal_busy        = '0;
    tx_manual          = '0;
    tx_digitalreset_or = '0;
    rx_is_lockedtodata = '0;
    rx_cal_busy        = '0;
    rx_manual          = '0;
    rx_digitalreset_or = '0;
    sample             = 1'b0;
    expected           = '0;
    row_index          = 0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset_sync = 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      lane      = $urandom % CHANNELS;
      row_index = i;
      apply_row(rows[i], lane);
      repeat (rows[i].hold) @(negedge clock);
      expected = rows[i].settled;
      sample   = 1'b1;  // Held a full cycle
      @(negedge clock);
      sample   = 1'b0;
    end
    @(negedge clock);
    if (check_count != NUM_ROWS * CHECKS_PER_ROW)
      $display("Monitor ran %0d checks, %0d were due", check_count,
               NUM_ROWS * CHECKS_PER_ROW);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
             error_count, dut_i.checker_i.fail_count);
    if (error_count == 0 && check_count == NUM_ROWS * CHECKS_PER_ROW
        && dut_i.checker_i.fail_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Twice the table length
  initial begin : watchdog
    longint limit_ns;
    limit_ns = 2 * hold_total() * CLOCK_PERIOD;
    #(limit_ns);
    $display("Timeout: stimulus table did not finish within %0d ns", limit_ns);
    $display("Test failures found");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
hw/xcvr_reset_pkg.sv
hw/xcvr_status_if.sv
hw/status_sync.sv
hw/reset_counter.sv
hw/tx_reset_seq.sv
hw/rx_reset_seq.sv
hw/xcvr_reset_control.sv
testbench/xcvr_reset_checker.sv
testbench/xcvr_reset_monitor.sv
testbench/xcvr_reset_tb.sv
